/* bus_pkg.sv */
/* Data bus definitions
   Bus widths plus the slave response state and GPIO register selects */

`default_nettype none

package bus_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int unsigned ADDRW = 16;        // Master byte address
    localparam int unsigned XLEN  = 32;
    localparam int unsigned STRBW = XLEN / 8;  // One strobe per byte lane

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Slave handshake and GPIO decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic {
        IDLE,   // Waiting for en
        RESP    // ready high for one cycle
    } slave_state_t;

    // Word offsets inside the GPIO window
    typedef enum logic [1:0] {
        GPIO_OUT = 2'd0,
        GPIO_DIR = 2'd1,
        GPIO_IN  = 2'd2
    } gpio_reg_t;

    localparam int unsigned GPIO_NREGS = 3;    // Offsets from here on are unmapped

endpackage

`default_nettype wire

/* mem_map_pkg.sv */
/* Data-side memory map
   Window bases and sizes, RAM geometry and GPIO pin count */

`default_nettype none

package mem_map_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address windows, in bytes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // GPIO register block
    localparam int unsigned GPIO_BASE_ADDR = 32'h0000;
    localparam int unsigned GPIO_BASE_SIZE = 32'h0800;

    // Data RAM, right above the GPIO window
    localparam int unsigned DATA_MEM_BASE_ADDR = 32'h0800;
    localparam int unsigned DATA_MEM_BASE_SIZE = 32'h1000;

    // Everything from 0x1800 upward is unmapped

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Derived geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int unsigned RAM_DEPTH = DATA_MEM_BASE_SIZE >> 2;  // Four bytes per word
    localparam int unsigned RAM_AW    = $clog2(RAM_DEPTH);        // Word index width

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // GPIO
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int unsigned GPIO_W = 8;  // Pins, all in byte lane 0

endpackage

`default_nettype wire

/* mem_router.sv */
/* Data-side address router
   Steers the master access to GPIO or data RAM, answers unmapped ones itself */

`timescale 1ns/1ps
`default_nettype none

module mem_router
    import bus_pkg::*;
    import mem_map_pkg::*;
(
    // Master side
    input  logic             mst_en,
    input  logic             mst_wr,
    input  logic [ADDRW-1:0] mst_addr,
    input  logic [XLEN-1:0]  mst_wdata,
    input  logic [STRBW-1:0] mst_strb,
    output logic [XLEN-1:0]  mst_rdata,
    output logic             mst_ready,
    // GPIO block
    output logic             gpio_en,
    output logic             gpio_wr,
    output logic [ADDRW-1:0] gpio_addr,
    output logic [XLEN-1:0]  gpio_wdata,
    output logic [STRBW-1:0] gpio_strb,
    input  logic [XLEN-1:0]  gpio_rdata,
    input  logic             gpio_ready,
    // Data RAM
    output logic             data_mem_en,
    output logic             data_mem_wr,
    output logic [ADDRW-1:0] data_mem_addr,
    output logic [XLEN-1:0]  data_mem_wdata,
    output logic [STRBW-1:0] data_mem_strb,
    input  logic [XLEN-1:0]  data_mem_rdata,
    input  logic             data_mem_ready
);

    logic [ADDRW-1:0] gpio_off;
    logic [ADDRW-1:0] mem_off;
    logic             gpio_hit;
    logic             mem_hit;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Range decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Offset compare, below-base addresses wrap high and miss
    assign gpio_off = mst_addr - ADDRW'(GPIO_BASE_ADDR);
    assign mem_off  = mst_addr - ADDRW'(DATA_MEM_BASE_ADDR);

    assign gpio_hit = (gpio_off < ADDRW'(GPIO_BASE_SIZE));
    assign mem_hit  = !gpio_hit && (mem_off < ADDRW'(DATA_MEM_BASE_SIZE));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Steering
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        // Idle slave ports by default
        gpio_en        = 1'b0;
        gpio_wr        = 1'b0;
        gpio_addr      = '0;
        gpio_wdata     = '0;
        gpio_strb      = '0;
        data_mem_en    = 1'b0;
        data_mem_wr    = 1'b0;
        data_mem_addr  = '0;
        data_mem_wdata = '0;
        data_mem_strb  = '0;

        // Unmapped access completes at once
        mst_rdata = '0;
        mst_ready = 1'b1;

        if (gpio_hit) begin
            gpio_en    = mst_en;
            gpio_wr    = mst_wr;
            gpio_addr  = mst_addr;
            gpio_wdata = mst_wdata;
            gpio_strb  = mst_strb;
            mst_rdata  = gpio_rdata;
            mst_ready  = gpio_ready;
        end else if (mem_hit) begin
            data_mem_en    = mst_en;
            data_mem_wr    = mst_wr;
            data_mem_addr  = mst_addr;
            data_mem_wdata = mst_wdata;
            data_mem_strb  = mst_strb;
            mst_rdata      = data_mem_rdata;
            mst_ready      = data_mem_ready;
        end
    end

endmodule

`default_nettype wire

/* gpio_regs.sv */
/* GPIO register block
   Output, direction and synchronized input registers behind the en/ready slave port */

`timescale 1ns/1ps
`default_nettype none

module gpio_regs
    import bus_pkg::*;
    import mem_map_pkg::*;
(
    input  logic              aclk,
    input  logic              arst_n,
    input  logic              srst,
    input  logic              en,
    input  logic              wr,
    input  logic [ADDRW-1:0]  addr,
    input  logic [XLEN-1:0]   wdata,
    input  logic [STRBW-1:0]  strb,
    output logic [XLEN-1:0]   rdata,
    output logic              ready,
    input  logic [GPIO_W-1:0] gpio_in,
    output logic [GPIO_W-1:0] gpio_out,
    output logic [GPIO_W-1:0] gpio_oe
);

    slave_state_t      state;
    logic              accept;
    logic [ADDRW-1:0]  gpio_off;
    logic [ADDRW-3:0]  word_off;
    logic              reg_hit;
    gpio_reg_t         reg_sel;
    logic [XLEN-1:0]   rd_data;
    logic [GPIO_W-1:0] sync_q;    // First synchronizer stage
    logic [GPIO_W-1:0] gpio_in_q; // GPIO_IN register

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign gpio_off = addr - ADDRW'(GPIO_BASE_ADDR);
    assign word_off = gpio_off[ADDRW-1:2];
    assign reg_hit  = (word_off < (ADDRW-2)'(GPIO_NREGS));
    assign reg_sel  = gpio_reg_t'(word_off[1:0]);

    assign accept = en && (state == IDLE) && !srst;
    assign ready  = (state == RESP);

    always_comb begin
        rd_data = '0;  // Unmapped offsets read zero
        if (reg_hit) begin
            case (reg_sel)
                GPIO_OUT: rd_data[GPIO_W-1:0] = gpio_out;
                GPIO_DIR: rd_data[GPIO_W-1:0] = gpio_oe;
                GPIO_IN:  rd_data[GPIO_W-1:0] = gpio_in_q;
                default:  rd_data = '0;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Handshake FSM and writable registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            gpio_out <= '0;
            gpio_oe  <= '0;
        end else if (srst) begin
            state    <= IDLE;
            gpio_out <= '0;
            gpio_oe  <= '0;
        end else begin
            state <= accept ? RESP : IDLE;  // RESP lasts one cycle
            if (accept && wr && reg_hit && strb[0]) begin
                case (reg_sel)
                    GPIO_OUT: gpio_out <= wdata[GPIO_W-1:0];
                    GPIO_DIR: gpio_oe  <= wdata[GPIO_W-1:0];
                    default: ;  // GPIO_IN is read only
                endcase
            end
        end
    end

    // Read data for the RESP cycle, zero on writes
    always_ff @(posedge aclk) begin
        if (accept) begin
            rdata <= wr ? '0 : rd_data;
        end
    end

    // Two-flop input synchronizer
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            sync_q    <= '0;
            gpio_in_q <= '0;
        end else begin
            sync_q    <= gpio_in;
            gpio_in_q <= sync_q;
        end
    end

endmodule

`default_nettype wire

/* data_ram.sv */
/* Data RAM
   1024-word single-port memory with byte strobes and a one-cycle response */

`timescale 1ns/1ps
`default_nettype none

module data_ram
    import bus_pkg::*;
    import mem_map_pkg::*;
(
    input  logic             aclk,
    input  logic             arst_n,
    input  logic             srst,
    input  logic             en,
    input  logic             wr,
    input  logic [ADDRW-1:0] addr,
    input  logic [XLEN-1:0]  wdata,
    input  logic [STRBW-1:0] strb,
    output logic [XLEN-1:0]  rdata,
    output logic             ready
);

    logic [XLEN-1:0]   mem [RAM_DEPTH];
    slave_state_t      state;
    logic              accept;
    logic [ADDRW-1:0]  mem_off;
    logic [RAM_AW-1:0] word_idx;

    // Byte offset into the window, then word index
    assign mem_off  = addr - ADDRW'(DATA_MEM_BASE_ADDR);
    assign word_idx = mem_off[RAM_AW+1:2];

    assign accept = en && (state == IDLE) && !srst;
    assign ready  = (state == RESP);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Handshake FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else if (srst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    state <= en ? RESP : IDLE;
                RESP:    state <= IDLE;  // en ignored here
                default: state <= IDLE;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge aclk) begin
        if (accept && wr) begin
            for (int i = 0; i < STRBW; i++) begin
                if (strb[i]) begin
                    mem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // Old word on reads
    always_ff @(posedge aclk) begin
        if (accept) begin
            rdata <= wr ? '0 : mem[word_idx];
        end
    end

endmodule

`default_nettype wire

/* data_subsys.sv */
/* Data-side memory subsystem
   Router in front of the GPIO block and the data RAM */

`timescale 1ns/1ps
`default_nettype none

module data_subsys
    import bus_pkg::*;
    import mem_map_pkg::*;
(
    input  logic              aclk,
    input  logic              arst_n,
    input  logic              srst,
    // Master port
    input  logic              en,
    input  logic              wr,
    input  logic [ADDRW-1:0]  addr,
    input  logic [XLEN-1:0]   wdata,
    input  logic [STRBW-1:0]  strb,
    output logic [XLEN-1:0]   rdata,
    output logic              ready,
    // Pins
    input  logic [GPIO_W-1:0] gpio_in,
    output logic [GPIO_W-1:0] gpio_out,
    output logic [GPIO_W-1:0] gpio_oe
);

    logic             gpio_en;
    logic             gpio_wr;
    logic [ADDRW-1:0] gpio_addr;
    logic [XLEN-1:0]  gpio_wdata;
    logic [STRBW-1:0] gpio_strb;
    logic [XLEN-1:0]  gpio_rdata;
    logic             gpio_ready;

    logic             data_mem_en;
    logic             data_mem_wr;
    logic [ADDRW-1:0] data_mem_addr;
    logic [XLEN-1:0]  data_mem_wdata;
    logic [STRBW-1:0] data_mem_strb;
    logic [XLEN-1:0]  data_mem_rdata;
    logic             data_mem_ready;

    mem_router router0 (
        .mst_en         (en),
        .mst_wr         (wr),
        .mst_addr       (addr),
        .mst_wdata      (wdata),
        .mst_strb       (strb),
        .mst_rdata      (rdata),
        .mst_ready      (ready),
        .gpio_en        (gpio_en),
        .gpio_wr        (gpio_wr),
        .gpio_addr      (gpio_addr),
        .gpio_wdata     (gpio_wdata),
        .gpio_strb      (gpio_strb),
        .gpio_rdata     (gpio_rdata),
        .gpio_ready     (gpio_ready),
        .data_mem_en    (data_mem_en),
        .data_mem_wr    (data_mem_wr),
        .data_mem_addr  (data_mem_addr),
        .data_mem_wdata (data_mem_wdata),
        .data_mem_strb  (data_mem_strb),
        .data_mem_rdata (data_mem_rdata),
        .data_mem_ready (data_mem_ready)
    );

    gpio_regs gpio0 (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .srst     (srst),
        .en       (gpio_en),
        .wr       (gpio_wr),
        .addr     (gpio_addr),
        .wdata    (gpio_wdata),
        .strb     (gpio_strb),
        .rdata    (gpio_rdata),
        .ready    (gpio_ready),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe)
    );

    data_ram ram0 (
        .aclk   (aclk),
        .arst_n (arst_n),
        .srst   (srst),
        .en     (data_mem_en),
        .wr     (data_mem_wr),
        .addr   (data_mem_addr),
        .wdata  (data_mem_wdata),
        .strb   (data_mem_strb),
        .rdata  (data_mem_rdata),
        .ready  (data_mem_ready)
    );

endmodule

`default_nettype wire

/* data_subsys_properties.sv */
/* Router assertions
   Slave selection and unmapped completion, checked on the router's nets */

`timescale 1ns/1ps
`default_nettype none

module data_subsys_properties
    import bus_pkg::*;
    import mem_map_pkg::*;
(
    input logic             aclk,
    input logic             arst_n,
    input logic             mst_en,
    input logic [ADDRW-1:0] mst_addr,
    input logic             mst_ready,
    input logic             gpio_en,
    input logic             data_mem_en
);

    logic [ADDRW-1:0] gpio_off;
    logic [ADDRW-1:0] mem_off;
    logic             unmapped;

    // Outside both windows
    assign gpio_off = mst_addr - ADDRW'(GPIO_BASE_ADDR);
    assign mem_off  = mst_addr - ADDRW'(DATA_MEM_BASE_ADDR);
    assign unmapped = (gpio_off >= ADDRW'(GPIO_BASE_SIZE))
                   && (mem_off >= ADDRW'(DATA_MEM_BASE_SIZE));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Properties
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_one_slave: assert property (@(posedge aclk) disable iff (!arst_n)
        !(gpio_en && data_mem_en))
        else $error("gpio_en and data_mem_en high together");

    a_unmapped_ready: assert property (@(posedge aclk) disable iff (!arst_n)
        (mst_en && unmapped) |-> mst_ready)
        else $error("unmapped access without ready in the same cycle");

    a_en_from_master: assert property (@(posedge aclk) disable iff (!arst_n)
        (gpio_en || data_mem_en) |-> mst_en)
        else $error("slave enable raised while mst_en is low");

endmodule

// Router nets meet the clock at the subsystem level
bind data_subsys data_subsys_properties props0 (
    .aclk        (aclk),
    .arst_n      (arst_n),
    .mst_en      (en),
    .mst_addr    (addr),
    .mst_ready   (ready),
    .gpio_en     (gpio_en),
    .data_mem_en (data_mem_en)
);

`default_nettype wire

/* tb_data_subsys.sv */
/* Data subsystem testbench
   Table of accesses checked against a RAM and GPIO model, plus pins, srst and random RAM traffic */

`timescale 1ns/1ps
`default_nettype none

module tb_data_subsys
    import bus_pkg::*;
    import mem_map_pkg::*;
();

    typedef enum logic [1:0] {
        ACT_ACCESS,
        ACT_SRST,
        ACT_PINS    // wdata low byte goes to the pins
    } action_t;

    typedef struct {
        string            name;
        action_t          act;
        logic             wr;
        logic [ADDRW-1:0] addr;
        logic [XLEN-1:0]  wdata;
        logic [STRBW-1:0] strb;
        logic [XLEN-1:0]  exp_rdata;
        logic             imm;      // Ready expected in the cycle en rises
        logic [GPIO_W-1:0] exp_out;
        logic [GPIO_W-1:0] exp_oe;
    } entry_t;

    logic              aclk;
    logic              arst_n;
    logic              srst;
    logic              en;
    logic              wr;
    logic [ADDRW-1:0]  addr;
    logic [XLEN-1:0]   wdata;
    logic [STRBW-1:0]  strb;
    logic [XLEN-1:0]   rdata;
    logic              ready;
    logic [GPIO_W-1:0] gpio_in;
    logic [GPIO_W-1:0] gpio_out;
    logic [GPIO_W-1:0] gpio_oe;

    entry_t            tbl [$];
    logic [XLEN-1:0]   ram_model [RAM_DEPTH];
    logic [GPIO_W-1:0] m_out;
    logic [GPIO_W-1:0] m_oe;
    logic [GPIO_W-1:0] m_in;
    logic [15:0]       lfsr_state;
    int                rand_count;
    int                n_checks;
    int                n_errors;
    int                wd_cycles;
    logic              table_ready;

    always #50 aclk = ~aclk;

    data_subsys dut0 (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .srst     (srst),
        .en       (en),
        .wr       (wr),
        .addr     (addr),
        .wdata    (wdata),
        .strb     (strb),
        .rdata    (rdata),
        .ready    (ready),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus source and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [31:0] lfsr_take(input int nbits);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            val        = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic void model_apply(input logic wr_in, input logic [ADDRW-1:0] a,
            input logic [XLEN-1:0] d, input logic [STRBW-1:0] s,
            output logic [XLEN-1:0] rd, output logic imm);
        int unsigned goff;
        int unsigned moff;
        goff = 32'(a) - GPIO_BASE_ADDR;
        moff = 32'(a) - DATA_MEM_BASE_ADDR;
        rd   = '0;
        imm  = 1'b0;
        if (goff < GPIO_BASE_SIZE) begin
            // Word 0 OUT, 1 DIR, 2 IN, rest unmapped
            if (wr_in) begin
                if (s[0] && (goff >> 2) == 0) m_out = d[GPIO_W-1:0];
                if (s[0] && (goff >> 2) == 1) m_oe = d[GPIO_W-1:0];
            end else begin
                case (goff >> 2)
                    0:       rd = XLEN'(m_out);
                    1:       rd = XLEN'(m_oe);
                    2:       rd = XLEN'(m_in);
                    default: rd = '0;
                endcase
            end
        end else if (moff < DATA_MEM_BASE_SIZE) begin
            if (wr_in) begin
                for (int b = 0; b < STRBW; b++) begin
                    if (s[b]) ram_model[moff >> 2][8*b +: 8] = d[8*b +: 8];
                end
            end else begin
                rd = ram_model[moff >> 2];
            end
        end else begin
            imm = 1'b1;  // Unmapped
        end
    endfunction

    task automatic add_entry(input string name, input action_t act, input logic wr_in,
            input logic [ADDRW-1:0] a, input logic [XLEN-1:0] d, input logic [STRBW-1:0] s);
        entry_t          e;
        logic [XLEN-1:0] rd;
        logic            imm;
        rd  = '0;
        imm = 1'b0;
        if (act == ACT_ACCESS) model_apply(wr_in, a, d, s, rd, imm);
        if (act == ACT_PINS) m_in = d[GPIO_W-1:0];
        if (act == ACT_SRST) begin
            m_out = '0;
            m_oe  = '0;
        end
        e.name      = name;
        e.act       = act;
        e.wr        = wr_in;
        e.addr      = a;
        e.wdata     = d;
        e.strb      = s;
        e.exp_rdata = rd;
        e.imm       = imm;
        e.exp_out   = m_out;
        e.exp_oe    = m_oe;
        tbl.push_back(e);
    endtask

    task automatic build_table();
        logic [ADDRW-1:0] rand_addr [$];
        int unsigned      idx;
        // RAM full then partial strobes
        add_entry("ram_w0", ACT_ACCESS, 1'b1, 16'h0800, 32'h11223344, 4'hf);
        add_entry("ram_w1", ACT_ACCESS, 1'b1, 16'h0804, 32'ha5a5a5a5, 4'hf);
        add_entry("ram_w2", ACT_ACCESS, 1'b1, 16'h17fc, 32'hcafef00d, 4'hf);
        add_entry("ram_p0", ACT_ACCESS, 1'b1, 16'h0800, 32'h000000ee, 4'h1);
        add_entry("ram_p1", ACT_ACCESS, 1'b1, 16'h0804, 32'h77660000, 4'hc);
        add_entry("ram_p2", ACT_ACCESS, 1'b1, 16'h17fc, 32'h0000ab00, 4'h2);
        add_entry("ram_r0", ACT_ACCESS, 1'b0, 16'h0800, 32'h0, 4'h0);
        add_entry("ram_r1", ACT_ACCESS, 1'b0, 16'h0804, 32'h0, 4'h0);
        add_entry("ram_r2", ACT_ACCESS, 1'b0, 16'h17fc, 32'h0, 4'h0);
        // GPIO registers
        add_entry("gpio_out_w", ACT_ACCESS, 1'b1, 16'h0000, 32'h1234565a, 4'hf);
        add_entry("gpio_dir_w", ACT_ACCESS, 1'b1, 16'h0004, 32'h000000c3, 4'h1);
        add_entry("gpio_out_r", ACT_ACCESS, 1'b0, 16'h0000, 32'h0, 4'h0);
        add_entry("gpio_dir_r", ACT_ACCESS, 1'b0, 16'h0004, 32'h0, 4'h0);
        add_entry("gpio_nostrb", ACT_ACCESS, 1'b1, 16'h0000, 32'h000000ff, 4'he);
        add_entry("gpio_in_w", ACT_ACCESS, 1'b1, 16'h0008, 32'h000000ff, 4'hf);
        // Unmapped offsets whose low index bits match DIR and OUT
        add_entry("gpio_bad_w", ACT_ACCESS, 1'b1, 16'h0014, 32'h000000ff, 4'hf);
        add_entry("gpio_bad_r0", ACT_ACCESS, 1'b0, 16'h000c, 32'h0, 4'h0);
        add_entry("gpio_bad_r1", ACT_ACCESS, 1'b0, 16'h07f0, 32'h0, 4'h0);
        add_entry("gpio_out_r2", ACT_ACCESS, 1'b0, 16'h0000, 32'h0, 4'h0);
        // Input pins through the synchronizer
        add_entry("pins_96", ACT_PINS, 1'b0, 16'h0, 32'h96, 4'h0);
        add_entry("gpio_in_r0", ACT_ACCESS, 1'b0, 16'h0008, 32'h0, 4'h0);
        add_entry("pins_3c", ACT_PINS, 1'b0, 16'h0, 32'h3c, 4'h0);
        add_entry("gpio_in_r1", ACT_ACCESS, 1'b0, 16'h0008, 32'h0, 4'h0);
        // Unmapped window
        add_entry("unm_w0", ACT_ACCESS, 1'b1, 16'h1800, 32'hffffffff, 4'hf);
        add_entry("unm_w1", ACT_ACCESS, 1'b1, 16'hfffc, 32'hffffffff, 4'hf);
        add_entry("unm_r0", ACT_ACCESS, 1'b0, 16'h1800, 32'h0, 4'h0);
        add_entry("unm_r1", ACT_ACCESS, 1'b0, 16'h2000, 32'h0, 4'h0);
        add_entry("unm_ram_r", ACT_ACCESS, 1'b0, 16'h0800, 32'h0, 4'h0);
        add_entry("unm_out_r", ACT_ACCESS, 1'b0, 16'h0000, 32'h0, 4'h0);
        add_entry("unm_dir_r", ACT_ACCESS, 1'b0, 16'h0004, 32'h0, 4'h0);
        // srst clears GPIO, keeps RAM
        add_entry("srst_pulse", ACT_SRST, 1'b0, 16'h0, 32'h0, 4'h0);
        add_entry("srst_out_r", ACT_ACCESS, 1'b0, 16'h0000, 32'h0, 4'h0);
        add_entry("srst_dir_r", ACT_ACCESS, 1'b0, 16'h0004, 32'h0, 4'h0);
        add_entry("srst_ram_r0", ACT_ACCESS, 1'b0, 16'h0800, 32'h0, 4'h0);
        add_entry("srst_ram_r1", ACT_ACCESS, 1'b0, 16'h17fc, 32'h0, 4'h0);
        // Random RAM traffic
        for (int i = 0; i < rand_count; i++) begin
            idx = lfsr_take(RAM_AW);
            rand_addr.push_back(ADDRW'(DATA_MEM_BASE_ADDR + idx * 4));
            add_entry($sformatf("rand_w%0d", i), ACT_ACCESS, 1'b1, rand_addr[i],
                lfsr_take(XLEN), 4'hf);
        end
        for (int i = 0; i < rand_count; i++) begin
            add_entry($sformatf("rand_r%0d", i), ACT_ACCESS, 1'b0, rand_addr[i], 32'h0, 4'h0);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Drivers and checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_word(input string name, input logic [XLEN-1:0] exp,
            input logic [XLEN-1:0] act);
        n_checks++;
        if (act !== exp) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            n_errors++;
        end
    endtask

    task automatic check_pins_out(input entry_t e);
        check_word({e.name, " gpio_out"}, XLEN'(e.exp_out), XLEN'(gpio_out));
        check_word({e.name, " gpio_oe"}, XLEN'(e.exp_oe), XLEN'(gpio_oe));
    endtask

    // Called at edge + 1 ns, returns at edge + 1 ns
    task automatic run_access(input entry_t e);
        int waited;
        waited = 0;
        en     = 1'b1;
        wr     = e.wr;
        addr   = e.addr;
        wdata  = e.wdata;
        strb   = e.strb;
        @(negedge aclk);
        while (!ready && waited < 8) begin
            @(negedge aclk);
            waited++;
        end
        if (!ready) begin
            $display("%s: no ready after %0d cycles", e.name, waited);
            n_errors++;
        end else begin
            n_checks++;
            if (waited != (e.imm ? 0 : 1)) begin
                $display("ERR %s ready cycles: expected %0d, actual %0d", e.name,
                    (e.imm ? 0 : 1), waited);
                n_errors++;
            end
            check_word({e.name, " rdata"}, e.exp_rdata, rdata);
            check_pins_out(e);
        end
        @(posedge aclk);
        #1;
        en    = 1'b0;
        wr    = 1'b0;
        addr  = '0;
        wdata = '0;
        strb  = '0;
    endtask

    task automatic run_entry(input entry_t e);
        case (e.act)
            ACT_SRST: begin
                srst = 1'b1;
                @(posedge aclk);
                #1;
                srst = 1'b0;
                @(negedge aclk);
                check_pins_out(e);
                @(posedge aclk);
                #1;
            end
            ACT_PINS: begin
                gpio_in = e.wdata[GPIO_W-1:0];
                repeat (3) @(posedge aclk);  // Two sync flops plus margin
                #1;
                check_pins_out(e);
            end
            default: run_access(e);
        endcase
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence and watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        aclk        = 1'b0;
        arst_n      = 1'b0;
        srst        = 1'b0;
        en          = 1'b0;
        wr          = 1'b0;
        addr        = '0;
        wdata       = '0;
        strb        = '0;
        gpio_in     = '0;
        m_out       = '0;
        m_oe        = '0;
        m_in        = '0;
        lfsr_state  = 16'd40;
        rand_count  = 32;
        n_checks    = 0;
        n_errors    = 0;
        table_ready = 1'b0;
        build_table();
        wd_cycles   = (tbl.size() + rand_count) * 4 + 100;
        table_ready = 1'b1;
        repeat (4) @(posedge aclk);
        #1;
        arst_n = 1'b1;
        @(posedge aclk);
        #1;
        for (int i = 0; i < tbl.size(); i++) begin
            run_entry(tbl[i]);
        end
        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        repeat (wd_cycles) @(posedge aclk);
        $display("Watchdog expired: run did not finish within %0d cycles", wd_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
bus_pkg.sv
mem_map_pkg.sv
mem_router.sv
gpio_regs.sv
data_ram.sv
data_subsys.sv
data_subsys_properties.sv
tb_data_subsys.sv

/* Makefile */
# Verilator build and run of the data-side memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_data_subsys
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# Pass only when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
